// ==== logic/readout_settings.svh ====
// readout merger build settings
// channel count, fifo sizing, hold threshold and epoch period
// fixed at compile time, no run-time configuration
`ifndef READOUT_SETTINGS_SVH
`define READOUT_SETTINGS_SVH

// hit channels feeding the merger
`define N_CHANNELS 4

// words held by each source fifo
`define FIFO_DEPTH 16

// fill level that raises hold_req and forces priority service
// keep below FIFO_DEPTH so the channel is served before it refuses hits
`define HOLD_LEVEL 12

// cycles between two epoch words while running
`define TS_PERIOD 64

// all hit channels plus one timestamp source, which sits in the last slot
`define N_SOURCES (`N_CHANNELS + 1)

`endif

// ==== logic/readout_pkg.sv ====
// data path types for the readout merger
// hit payloads, epoch numbers, source tags and the tagged output word

package readout_pkg;

    // source tag in the top nibble of every output word
    typedef logic [3:0] src_tag_t;

    // timestamp source tag, hit channels use their index
    localparam src_tag_t TS_TAG = 4'hF;

    // hit as delivered by a front-end channel
    typedef struct packed {
        logic [7:0]  col;     // pixel column
        logic [7:0]  row;     // pixel row
        logic [11:0] charge;  // tot / adc value
    } hit_payload_t;

    // running epoch count from the timer, same width as a hit
    typedef logic [27:0] epoch_t;

    // merged stream word
    typedef struct packed {
        src_tag_t    tag;   // who produced it
        logic [27:0] body;  // hit or epoch, untouched
    } out_word_t;

endpackage

// ==== logic/ctrl_pkg.sv ====
// run control types for the readout merger
// three phases of a run, idle, taking data, and emptying the fifos

package ctrl_pkg;

    // 2-bit encoding, IDLE is the reset value
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // waiting for start
        RUN   = 2'd1,  // hits accepted, timer running
        DRAIN = 2'd2   // inputs closed, fifos emptying
    } run_state_t;

endpackage

// ==== logic/arb_bus_if.sv ====
// source to arbiter bus of the readout merger
// per-source request, hold, head word and grant vectors
// each source drives only its own slot

`timescale 1ns/1ps

`include "readout_settings.svh"

interface arb_bus_if import readout_pkg::*; #(
    parameter int N_SRC = `N_SOURCES
) ();

    logic [N_SRC-1:0] write_req;   // source not empty
    logic [N_SRC-1:0] hold_req;    // source at or above high-water mark
    out_word_t        data [N_SRC]; // tagged head word per source
    logic [N_SRC-1:0] read_grant;  // pop strobe back to the source

    // fifo side
    modport source (
        output write_req,
        output hold_req,
        output data,
        input  read_grant
    );

    // merger side
    modport arbiter (
        input  write_req,
        input  hold_req,
        input  data,
        output read_grant
    );

endinterface

// ==== logic/channel_fifo.sv ====
// source fifo of the readout merger
// circular buffer with a fill counter, one per hit channel plus one for epochs
// presents its head word with the source tag on its bus slot
// raises hold_req once the fill level reaches the high-water mark

`timescale 1ns/1ps

`include "readout_settings.svh"

module channel_fifo import readout_pkg::*; #(
    parameter type      payload_t = hit_payload_t,
    parameter src_tag_t TAG       = '0
) (
    input  logic          CLK,
    input  logic          RST,
    input  logic          wr_en,
    input  payload_t      wr_data,
    output logic          full,
    output logic          empty,
    arb_bus_if.source     bus
);

    // bus slot, epoch source lives in the last one
    localparam int SLOT  = (TAG == TS_TAG) ? `N_SOURCES - 1 : int'(TAG);
    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    payload_t         mem [`FIFO_DEPTH]; // storage, no reset needed
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;             // words held
    logic             push;
    logic             pop;

    assign full  = (count == CNT_W'(`FIFO_DEPTH));
    assign empty = (count == '0);

    assign push = wr_en && !full;                 // refused when full
    assign pop  = bus.read_grant[SLOT] && !empty;

    // head word, tagged on the way out
    assign bus.data[SLOT]      = '{tag: TAG, body: mem[rd_ptr]};
    assign bus.write_req[SLOT] = !empty;
    assign bus.hold_req[SLOT]  = (count >= CNT_W'(`HOLD_LEVEL));

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the level
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/rrp_arbiter.sv ====
// round-robin merger with hold priority
// lowest source with hold_req wins, otherwise next requester after the last one
// the offered word is locked until out_ready takes it
// selection and output are combinational, pointer and lock are registered

`timescale 1ns/1ps

`include "readout_settings.svh"

module rrp_arbiter import readout_pkg::*; #(
    parameter int N_SRC = `N_SOURCES
) (
    input  logic       CLK,
    input  logic       RST,
    input  logic       out_ready,
    output logic       out_valid,
    output out_word_t  out_data,
    arb_bus_if.arbiter bus
);

    logic [N_SRC-1:0] prev_sel; // one-hot, last source offered
    logic [N_SRC-1:0] sel;      // one-hot, current choice
    logic             lock;     // word on the output, waiting for ready
    logic             any_hold;
    logic             any_req;
    logic [31:0]      data_or;

    // one-hot rotate towards higher sources, wraps to slot 0
    function automatic logic [N_SRC-1:0] rotl(input logic [N_SRC-1:0] v, input int k);
        logic [2*N_SRC-1:0] d;
        d = {v, v} << k;
        return d[2*N_SRC-1:N_SRC];
    endfunction

    assign any_hold = |bus.hold_req;
    assign any_req  = |bus.write_req;

    always_comb begin
        sel = prev_sel; // locked or nothing pending
        if (!lock && any_hold) begin
            // scan down so the lowest holder is kept
            for (int i = N_SRC - 1; i >= 0; i--) begin
                if (bus.hold_req[i]) sel = N_SRC'(1) << i;
            end
        end else if (!lock && any_req) begin
            // largest step first, smallest step with a request wins
            for (int k = N_SRC; k >= 1; k--) begin
                if (|(bus.write_req & rotl(prev_sel, k))) sel = rotl(prev_sel, k);
            end
        end
    end

    assign out_valid      = |(bus.write_req & sel);
    assign bus.read_grant = sel & {N_SRC{out_valid & out_ready}}; // pop on transfer only

    // and-or mux over the head words
    always_comb begin
        data_or = '0;
        for (int i = 0; i < N_SRC; i++) begin
            if (sel[i]) data_or = data_or | bus.data[i];
        end
    end
    assign out_data = data_or;

    always_ff @(posedge CLK) begin
        if (RST) begin
            prev_sel <= N_SRC'(1) << (N_SRC - 1); // slot 0 goes first
        end else if (any_req && !lock) begin
            prev_sel <= sel;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            lock <= 1'b0;
        end else if (out_ready) begin
            lock <= 1'b0;  // taken or nothing offered
        end else if (out_valid) begin
            lock <= 1'b1;  // stalled, keep the same word
        end
    end

endmodule

// ==== logic/timestamp_timer.sv ====
// epoch timer of the readout merger
// counts cycles while enabled, one ts_valid strobe every TS_PERIOD cycles
// epoch number restarts at zero with each run

`timescale 1ns/1ps

`include "readout_settings.svh"

module timestamp_timer import readout_pkg::*; (
    input  logic   CLK,
    input  logic   RST,
    input  logic   ts_en,
    output logic   ts_valid,
    output epoch_t ts_epoch
);

    localparam int CNT_W = $clog2(`TS_PERIOD);

    logic [CNT_W-1:0] cnt; // cycles into the current period

    // last cycle of the period, fifo takes the word on this edge
    assign ts_valid = ts_en && (cnt == CNT_W'(`TS_PERIOD - 1));

    always_ff @(posedge CLK) begin
        if (RST || !ts_en) begin
            cnt      <= '0;  // held clear outside a run
            ts_epoch <= '0;
        end else if (ts_valid) begin
            cnt      <= '0;
            ts_epoch <= ts_epoch + 1'b1; // next epoch number
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== logic/readout_ctrl.sv ====
// run control of the readout merger
// start opens the inputs and the timer, stop closes them
// then waits for every source fifo to empty and pulses done

`timescale 1ns/1ps

module readout_ctrl import ctrl_pkg::*; (
    input  logic CLK,
    input  logic RST,
    input  logic start,     // strobe, used in IDLE only
    input  logic stop,      // strobe, used in RUN only
    input  logic all_empty, // every source fifo empty
    output logic accept_en,
    output logic ts_en,
    output logic busy,
    output logic done
);

    run_state_t state;
    run_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = RUN;
            RUN:     if (stop) state_nxt = DRAIN;
            DRAIN:   if (all_empty) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // high for the first IDLE cycle after the drain
            done  <= (state == DRAIN) && all_empty;
        end
    end

    assign accept_en = (state == RUN);
    assign ts_en     = (state == RUN);  // timer stops with the inputs
    assign busy      = (state != IDLE);

endmodule

// ==== logic/readout_top.sv ====
// readout merger top level
// hit channels and the epoch timer each fill a tagged fifo
// the arbiter merges all fifos into one 32-bit stream
// run control gates hit acceptance and the timer

`timescale 1ns/1ps

`include "readout_settings.svh"

module readout_top import readout_pkg::*; (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   start,
    input  logic                   stop,
    input  logic [`N_CHANNELS-1:0] in_valid,
    input  hit_payload_t           in_data [`N_CHANNELS],
    input  logic                   out_ready,
    output logic [`N_CHANNELS-1:0] in_full,
    output logic                   out_valid,
    output out_word_t              out_data,
    output logic                   busy,
    output logic                   done
);

    logic                   accept_en;
    logic                   ts_en;
    logic                   ts_valid;
    epoch_t                 ts_epoch;
    logic [`N_CHANNELS-1:0] hit_wr;    // gated hit writes
    logic [`N_SOURCES-1:0]  src_empty; // hit fifos, epoch fifo on top
    logic                   all_empty;

    arb_bus_if #(.N_SRC(`N_SOURCES)) bus ();

    assign all_empty = &src_empty;

    readout_ctrl i_readout_ctrl (
        .CLK       (CLK),
        .RST       (RST),
        .start     (start),
        .stop      (stop),
        .all_empty (all_empty),
        .accept_en (accept_en),
        .ts_en     (ts_en),
        .busy      (busy),
        .done      (done)
    );

    timestamp_timer i_timestamp_timer (
        .CLK      (CLK),
        .RST      (RST),
        .ts_en    (ts_en),
        .ts_valid (ts_valid),
        .ts_epoch (ts_epoch)
    );

    for (genvar i = 0; i < `N_CHANNELS; i++) begin : g_hit
        assign hit_wr[i] = in_valid[i] & accept_en; // closed outside RUN

        channel_fifo #(
            .payload_t (hit_payload_t),
            .TAG       (src_tag_t'(i))
        ) i_channel_fifo (
            .CLK     (CLK),
            .RST     (RST),
            .wr_en   (hit_wr[i]),
            .wr_data (in_data[i]),
            .full    (in_full[i]),
            .empty   (src_empty[i]),
            .bus     (bus.source)
        );
    end

    // epoch words dropped when this one is full
    channel_fifo #(
        .payload_t (epoch_t),
        .TAG       (TS_TAG)
    ) i_epoch_fifo (
        .CLK     (CLK),
        .RST     (RST),
        .wr_en   (ts_valid),
        .wr_data (ts_epoch),
        .full    (),
        .empty   (src_empty[`N_SOURCES-1]),
        .bus     (bus.source)
    );

    rrp_arbiter #(.N_SRC(`N_SOURCES)) i_rrp_arbiter (
        .CLK       (CLK),
        .RST       (RST),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .bus       (bus.arbiter)
    );

endmodule

// ==== sim/readout_props.sv ====
// protocol properties of the readout merger
// bound into the top level, watches the arbiter grants and run control
`timescale 1ns/1ps

`include "readout_settings.svh"

module readout_props import ctrl_pkg::*; #(
    parameter int N_SRC = `N_SOURCES
) (
    input logic                   CLK,
    input logic                   RST,
    input logic                   out_valid,
    input logic [N_SRC-1:0]       read_grant,
    input logic                   done,
    input run_state_t             state,
    input logic [`N_CHANNELS-1:0] hit_wr
);

    // fifos are cleared by reset, so nothing is offered right after
    a_quiet_after_reset: assert property (@(posedge CLK) RST |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_grant_onehot: assert property (@(posedge CLK) disable iff (RST) $onehot0(read_grant))
        else $error("read_grant has more than one bit set");

    a_done_pulse: assert property (@(posedge CLK) disable iff (RST) done |=> !done)
        else $error("done held longer than one cycle");

    // inputs closed once stop was seen
    a_no_hit_in_drain: assert property (@(posedge CLK) disable iff (RST)
        (state == DRAIN) |-> (hit_wr == '0))
        else $error("hit accepted during drain");

endmodule

bind readout_top readout_props i_readout_props (
    .CLK        (CLK),
    .RST        (RST),
    .out_valid  (out_valid),
    .read_grant (bus.read_grant),
    .done       (done),
    .state      (i_readout_ctrl.state),
    .hit_wr     (hit_wr)
);

// ==== sim/readout_tb.sv ====
// testbench for the readout merger
// directed runs on the hit channels, back-pressure, hold priority, epochs and drain
// expected words are kept in one queue per source tag, epochs are modelled by count
`timescale 1ns/1ps

`include "readout_settings.svh"

module readout_tb import readout_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_CYCLES = 16 + 3 * `TS_PERIOD + 6 * 150; // reset, epoch wait, other runs
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

    logic                   CLK;
    logic                   RST;
    logic                   start;
    logic                   stop;
    logic [`N_CHANNELS-1:0] in_valid;
    hit_payload_t           in_data [`N_CHANNELS];
    logic                   out_ready;
    logic [`N_CHANNELS-1:0] in_full;
    logic                   out_valid;
    out_word_t              out_data;
    logic                   busy;
    logic                   done;

    logic [27:0] exp_q [`N_CHANNELS][$]; // expected hit bodies per channel
    logic [31:0] lcg_state = 32'h72097303;
    epoch_t      next_epoch;   // epoch number due next
    int          epoch_rx;
    int          done_count;
    int          err_count;
    logic [3:0]  last_tag;     // tag of the previous output word
    bit          rr_check;     // round-robin order check on
    bit          hold_check;   // hold priority check on

    readout_top i_readout_top (
        .CLK(CLK), .RST(RST), .start(start), .stop(stop),
        .in_valid(in_valid), .in_data(in_data), .out_ready(out_ready),
        .in_full(in_full), .out_valid(out_valid), .out_data(out_data),
        .busy(busy), .done(done)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int exp_total();
        int n;
        n = 0;
        for (int c = 0; c < `N_CHANNELS; c++) n += exp_q[c].size();
        return n;
    endfunction

    task automatic finish_fail();
        err_count++;
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic value_error(input string what);
        $display("** Error at %0t ns: %s", $time, what);
        finish_fail();
    endtask

    // output monitor, sampled on the rising edge before any register update
    task automatic check_word(input out_word_t w);
        bit all_busy;
        all_busy = 1'b1;
        for (int c = 0; c < `N_CHANNELS; c++) if (exp_q[c].size() == 0) all_busy = 1'b0;
        if (w.tag == TS_TAG) begin
            assert (w.body == next_epoch) else value_error($sformatf(
                "epoch %0d, expected %0d", w.body, next_epoch));
            next_epoch++;
            epoch_rx++;
        end else begin
            assert (w.tag < `N_CHANNELS && exp_q[w.tag].size() > 0) else value_error(
                $sformatf("unexpected word %h", w));
            if (rr_check && all_busy && last_tag < `N_CHANNELS)
                assert (w.tag == (last_tag + 1) % `N_CHANNELS) else value_error($sformatf(
                    "tag %0d after %0d breaks round-robin", w.tag, last_tag));
            if (hold_check && exp_q[3].size() >= `HOLD_LEVEL)
                assert (w.tag == 4'd3) else value_error($sformatf(
                    "tag %0d served while channel 3 holds", w.tag));
            assert (w.body == exp_q[w.tag][0]) else value_error($sformatf(
                "tag %0d body %h, expected %h", w.tag, w.body, exp_q[w.tag][0]));
            void'(exp_q[w.tag].pop_front());
        end
        last_tag = w.tag;
    endtask

    always @(posedge CLK) begin
        if (!RST) begin
            if (done) begin
                done_count++;
                assert (exp_total() == 0) else value_error("done with words outstanding");
            end
            if (out_valid && out_ready) check_word(out_data);
        end
    end

    // state after reset, nothing running and nothing stored
    task automatic expect_idle_outputs();
        assert (!busy && !done && !out_valid && in_full == '0) else value_error($sformatf(
            "after reset busy %b done %b out_valid %b in_full %b",
            busy, done, out_valid, in_full));
    endtask

    // one write cycle on the masked channels, accepted words go to the queues
    task automatic drive_hits(input logic [`N_CHANNELS-1:0] mask, input bit accept);
        logic [31:0] r;
        @(negedge CLK);
        for (int c = 0; c < `N_CHANNELS; c++) begin
            if (mask[c]) begin
                r = lcg_next();
                in_data[c] = r[27:0];
                if (accept) exp_q[c].push_back(r[27:0]);
            end
        end
        in_valid = mask;
    endtask

    task automatic release_hits();
        @(negedge CLK);
        in_valid = '0;
    endtask

    task automatic start_run();
        @(negedge CLK);
        start      = 1'b1;
        next_epoch = '0;  // timer restarts with the run
        epoch_rx   = 0;
        @(negedge CLK);
        start = 1'b0;
    endtask

    task automatic pulse_stop();
        @(negedge CLK);
        stop = 1'b1;
        @(negedge CLK);
        stop = 1'b0;
    endtask

    // busy must hold while anything is still expected
    task automatic wait_done();
        int prev;
        int n;
        prev = done_count;
        n = 0;
        while (done_count == prev) begin
            @(negedge CLK);
            if (exp_total() > 0) assert (busy) else value_error("busy low with words left");
            n++;
            if (n > 200) begin
                $display("timeout: done never came after stop");
                finish_fail();
            end
        end
    endtask

    task automatic single_channel_order();
        out_ready = 1'b1;
        start_run();
        for (int i = 0; i < 10; i++) drive_hits(4'b0100, 1'b1);
        release_hits();
        pulse_stop();
        wait_done();
    endtask

    task automatic round_robin_order();
        out_ready = 1'b1;
        last_tag  = TS_TAG;
        rr_check  = 1'b1;
        start_run();
        for (int i = 0; i < 8; i++) drive_hits(4'hF, 1'b1);
        release_hits();
        pulse_stop();
        wait_done();
        rr_check = 1'b0;
    endtask

    task automatic back_pressure_stall();
        out_word_t              held;
        logic [`N_CHANNELS-1:0] full_exp; // only channel 1 is loaded
        out_ready = 1'b0;
        start_run();
        for (int i = 0; i < `FIFO_DEPTH + 3; i++) begin
            drive_hits(4'b0010, i < `FIFO_DEPTH); // extra hits hit a full fifo
            full_exp    = '0;
            full_exp[1] = (i >= `FIFO_DEPTH);
            assert (in_full == full_exp) else value_error($sformatf(
                "in_full %b after %0d writes to channel 1, expected %b",
                in_full, i, full_exp));
        end
        release_hits();
        held = out_data;
        repeat (5) begin
            @(negedge CLK);
            assert (out_valid && out_data == held) else value_error("stalled word moved");
        end
        out_ready = 1'b1;
        pulse_stop();
        wait_done();
    endtask

    task automatic hold_priority_order();
        out_ready = 1'b0;
        start_run();
        for (int i = 0; i < `HOLD_LEVEL + 2; i++) drive_hits(4'b1000, 1'b1);
        for (int i = 0; i < 3; i++) drive_hits(4'b0011, 1'b1);
        release_hits();
        hold_check = 1'b1;
        out_ready  = 1'b1;
        pulse_stop();
        wait_done();
        hold_check = 1'b0;
    endtask

    task automatic epoch_numbering();
        out_ready = 1'b1;
        start_run();
        repeat (3 * `TS_PERIOD + 8) @(negedge CLK);
        pulse_stop();
        wait_done();
        assert (epoch_rx == 3) else value_error($sformatf("%0d epoch words, expected 3", epoch_rx));
    endtask

    task automatic stop_and_drain();
        int prev;
        out_ready = 1'b0;
        start_run();
        for (int i = 0; i < 5; i++) drive_hits(4'hF, 1'b1);
        release_hits();
        pulse_stop();
        prev = done_count;
        for (int i = 0; i < 3; i++) drive_hits(4'hF, 1'b0); // refused in DRAIN
        release_hits();
        repeat (6) begin
            @(negedge CLK);
            assert (busy && done_count == prev) else value_error("drain ended with words held");
        end
        out_ready = 1'b1;
        wait_done();
        repeat (4) @(negedge CLK);
        assert (done_count == prev + 1 && !busy) else value_error(
            $sformatf("done pulsed %0d times", done_count - prev));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: simulation ran past its time limit");
        finish_fail();
    end

    initial begin
        RST = 1'b1;
        start = 1'b0;
        stop = 1'b0;
        in_valid = '0;
        for (int c = 0; c < `N_CHANNELS; c++) in_data[c] = '0;
        out_ready = 1'b0;
        done_count = 0;
        err_count = 0;
        epoch_rx = 0;
        next_epoch = '0;
        last_tag = TS_TAG;
        rr_check = 1'b0;
        hold_check = 1'b0;
        repeat (16) @(negedge CLK);
        RST = 1'b0;
        expect_idle_outputs();
        single_channel_order();
        round_robin_order();
        back_pressure_stall();
        hold_priority_order();
        epoch_numbering();
        stop_and_drain();
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/readout_pkg.sv
logic/ctrl_pkg.sv
logic/arb_bus_if.sv
logic/channel_fifo.sv
logic/rrp_arbiter.sv
logic/timestamp_timer.sv
logic/readout_ctrl.sv
logic/readout_top.sv
sim/readout_props.sv
sim/readout_tb.sv

// ==== Bender.yml ====
package:
  name: readout_merger

sources:
  - include_dirs:
      - logic
    files:
      - logic/readout_pkg.sv
      - logic/ctrl_pkg.sv
      - logic/arb_bus_if.sv
      - logic/channel_fifo.sv
      - logic/rrp_arbiter.sv
      - logic/timestamp_timer.sv
      - logic/readout_ctrl.sv
      - logic/readout_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - sim/readout_props.sv
      - sim/readout_tb.sv
